// ==== decode_pkg.sv ====
/*
 * Shared types and constants for the decode stage
 * Word and register index types, operation and format enums,
 * the canonical NOP encoding and the RV32 major opcodes
 */
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Operations seen by the execute stage
    typedef enum logic [5:0] {
        NOP, LUI, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        JAL, JALR, BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU, SB, SH, SW,
        INVALID
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } fmt_e;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // Major opcodes in instr[6:0]
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

endpackage

// ==== decode_if.sv ====
/*
 * Decoded instruction bundle
 * Driven by the operation decoder, read by operand, hazard and output logic
 */
`timescale 1ns/100ps

interface decode_if;
    import decode_pkg::*;

    word_t  instr;
    op_e    op;
    fmt_e   fmt;
    logic   invalid;

    modport decoder (
        output instr, op, fmt, invalid
    );

    modport consumer (
        input instr, op, fmt, invalid
    );

endinterface

// ==== instr_replay.sv ====
/*
 * Instruction replay buffer
 * Re-presents the last instruction after a hazard or a stall
 */
`timescale 1ns/100ps

module instr_replay (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              enable_i,
    input  logic              hazard_i,
    input  decode_pkg::word_t instr_i,
    output decode_pkg::word_t instr_o
);
    import decode_pkg::*;

    word_t last_instr;
    logic  last_hazard;
    logic  last_stall;

    // Flags start set so the first cycle decodes a NOP
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_instr  <= NOP_INSTR;
            last_hazard <= 1'b1;
            last_stall  <= 1'b1;
        end else begin
            last_instr  <= instr_o;
            last_hazard <= hazard_i;
            last_stall  <= !enable_i;
        end
    end

    assign instr_o = (last_hazard || last_stall) ? last_instr : instr_i;

endmodule

// ==== op_decoder.sv ====
/*
 * Operation decoder for RV32IM
 * Maps opcode, funct3 and funct7 to an operation, a format and an illegal flag
 */
`timescale 1ns/100ps

module op_decoder (
    input  decode_pkg::word_t instr_i,
    decode_if.decoder         dec
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op_branch;
    op_e        op_load;
    op_e        op_store;
    op_e        op_imm;
    op_e        op_reg;
    op_e        op;
    fmt_e       fmt;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////////////////////////////////////////
    // Per-opcode funct decoding
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Only the shift immediates constrain funct7
    always_comb begin
        case (funct3)
            3'b000:  op_imm = ADD;
            3'b001:  op_imm = (funct7 == 7'b0000000) ? SLL : INVALID;
            3'b010:  op_imm = SLT;
            3'b011:  op_imm = SLTU;
            3'b100:  op_imm = XOR;
            3'b101:  op_imm = (funct7 == 7'b0000000) ? SRL :
                              (funct7 == 7'b0100000) ? SRA : INVALID;
            3'b110:  op_imm = OR;
            default: op_imm = AND;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: op_reg = ADD;
            10'b0100000_000: op_reg = SUB;
            10'b0000000_001: op_reg = SLL;
            10'b0000000_010: op_reg = SLT;
            10'b0000000_011: op_reg = SLTU;
            10'b0000000_100: op_reg = XOR;
            10'b0000000_101: op_reg = SRL;
            10'b0100000_101: op_reg = SRA;
            10'b0000000_110: op_reg = OR;
            10'b0000000_111: op_reg = AND;
            // M extension
            10'b0000001_000: op_reg = MUL;
            10'b0000001_001: op_reg = MULH;
            10'b0000001_010: op_reg = MULHSU;
            10'b0000001_011: op_reg = MULHU;
            10'b0000001_100: op_reg = DIV;
            10'b0000001_101: op_reg = DIVU;
            10'b0000001_110: op_reg = REM;
            10'b0000001_111: op_reg = REMU;
            default:         op_reg = INVALID;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operation and format
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_LUI:      op = LUI;
            OPC_AUIPC:    op = ADD;
            OPC_JAL:      op = JAL;
            OPC_JALR:     op = JALR;
            OPC_BRANCH:   op = op_branch;
            OPC_LOAD:     op = op_load;
            OPC_STORE:    op = op_store;
            OPC_OP_IMM:   op = op_imm;
            OPC_OP:       op = op_reg;
            // FENCE has no effect on this in-order core
            OPC_MISC_MEM: op = (funct3 == 3'b000) ? NOP : INVALID;
            default:      op = INVALID;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: fmt = I_TYPE;
            OPC_STORE:                      fmt = S_TYPE;
            OPC_BRANCH:                     fmt = B_TYPE;
            OPC_LUI, OPC_AUIPC:             fmt = U_TYPE;
            OPC_JAL:                        fmt = J_TYPE;
            default:                        fmt = R_TYPE;
        endcase
    end

    assign dec.instr   = instr_i;
    assign dec.op      = op;
    assign dec.fmt     = fmt;
    assign dec.invalid = (op == INVALID);

endmodule

// ==== operand_gen.sv ====
/*
 * Immediate extraction and operand selection
 * Also drives the register-file read addresses
 */
`timescale 1ns/100ps

module operand_gen (
    decode_if.consumer             dec,
    input  decode_pkg::word_t      pc_i,
    input  decode_pkg::word_t      rs1_data_i,
    input  decode_pkg::word_t      rs2_data_i,
    output decode_pkg::word_t      first_op_o,
    output decode_pkg::word_t      second_op_o,
    output decode_pkg::word_t      third_op_o,
    output decode_pkg::reg_addr_t  rs1_o,
    output decode_pkg::reg_addr_t  rs2_o
);
    import decode_pkg::*;

    word_t instr;
    word_t imm;

    assign instr = dec.instr;

    // Sign-extended immediate by format, zero for R
    always_comb begin
        case (dec.fmt)
            I_TYPE:  imm = {{21{instr[31]}}, instr[30:20]};
            S_TYPE:  imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            B_TYPE:  imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            U_TYPE:  imm = {instr[31:12], 12'b0};
            J_TYPE:  imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand muxes
    ////////////////////////////////////////////////////////////////////////////

    assign first_op_o = (dec.fmt == U_TYPE || dec.fmt == J_TYPE) ? pc_i : rs1_data_i;

    assign second_op_o = (dec.fmt == R_TYPE || dec.fmt == B_TYPE) ? rs2_data_i : imm;

    // Store data rides on the third operand
    assign third_op_o = (dec.fmt == S_TYPE) ? rs2_data_i : imm;

    assign rs1_o = instr[19:15];
    assign rs2_o = instr[24:20];

endmodule

// ==== hazard_unit.sv ====
/*
 * Hazard detection against the previously issued instruction
 * Locked destination register, pending store flag and delayed rd
 */
`timescale 1ns/100ps

module hazard_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  logic                   jumped_i,
    decode_if.consumer             dec,
    output logic                   hazard_o,
    output decode_pkg::reg_addr_t  rd_o
);
    import decode_pkg::*;

    reg_addr_t locked_rd;
    logic      locked_store;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_rs1;
    logic      use_rs2;
    logic      hazard_rs1;
    logic      hazard_rs2;
    logic      hazard_mem;

    assign rs1 = dec.instr[19:15];
    assign rs2 = dec.instr[24:20];

    // U and J read no register, I reads only rs1
    assign use_rs1 = (dec.fmt == R_TYPE) || (dec.fmt == I_TYPE) ||
                     (dec.fmt == S_TYPE) || (dec.fmt == B_TYPE);
    assign use_rs2 = (dec.fmt == R_TYPE) || (dec.fmt == S_TYPE) || (dec.fmt == B_TYPE);

    assign hazard_rs1 = use_rs1 && (rs1 != '0) && (rs1 == locked_rd);
    assign hazard_rs2 = use_rs2 && (rs2 != '0) && (rs2 == locked_rd);
    assign hazard_mem = locked_store && (dec.instr[6:0] == OPC_LOAD);

    assign hazard_o = (hazard_rs1 || hazard_rs2 || hazard_mem) && enable_i && !jumped_i;

    ////////////////////////////////////////////////////////////////////////////
    // Lock of the last issued instruction
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_rd    <= '0;
            locked_store <= 1'b0;
        end else if (hazard_o) begin
            // Bubble issued, nothing left in flight
            locked_rd    <= '0;
            locked_store <= 1'b0;
        end else if (enable_i) begin
            locked_rd    <= dec.instr[11:7];
            locked_store <= (dec.instr[6:0] == OPC_STORE);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_o <= '0;
        end else if (enable_i) begin
            rd_o <= locked_rd;
        end
    end

endmodule

// ==== decode_out_reg.sv ====
/*
 * Decode output pipeline register
 * Issues the decoded instruction or a bubble, flags illegal and misaligned fetch
 */
`timescale 1ns/100ps

module decode_out_reg #(
    parameter bit COMPRESSED = 1'b1
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               enable_i,
    input  logic               hazard_i,
    decode_if.consumer         dec,
    input  decode_pkg::word_t  pc_i,
    input  decode_pkg::word_t  first_op_i,
    input  decode_pkg::word_t  second_op_i,
    input  decode_pkg::word_t  third_op_i,
    output decode_pkg::word_t  first_op_o,
    output decode_pkg::word_t  second_op_o,
    output decode_pkg::word_t  third_op_o,
    output decode_pkg::word_t  pc_o,
    output decode_pkg::word_t  instr_o,
    output decode_pkg::op_e    op_o,
    output logic               exc_illegal_o,
    output logic               exc_misaligned_o
);
    import decode_pkg::*;

    logic misaligned;

    // Halfword alignment is enough with compressed fetch
    assign misaligned = COMPRESSED ? pc_i[0] : (pc_i[1:0] != 2'b00);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            first_op_o       <= '0;
            second_op_o      <= '0;
            third_op_o       <= '0;
            pc_o             <= '0;
            instr_o          <= '0;
            op_o             <= NOP;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (hazard_i) begin
            // Bubble
            first_op_o       <= '0;
            second_op_o      <= '0;
            third_op_o       <= '0;
            pc_o             <= '0;
            instr_o          <= '0;
            op_o             <= NOP;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (enable_i) begin
            first_op_o       <= first_op_i;
            second_op_o      <= second_op_i;
            third_op_o       <= third_op_i;
            pc_o             <= pc_i;
            instr_o          <= dec.instr;
            op_o             <= dec.op;
            exc_illegal_o    <= dec.invalid;
            exc_misaligned_o <= misaligned;
        end
    end

endmodule

// ==== decode_stage.sv ====
/*
 * Decode stage top level
 * Replay buffer, decoder, operand generator, hazard unit and output register
 */
`timescale 1ns/100ps

module decode_stage #(
    parameter bit COMPRESSED = 1'b1
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  logic                   jumped_i,
    input  decode_pkg::word_t      instr_i,
    input  decode_pkg::word_t      pc_i,
    input  decode_pkg::word_t      rs1_data_i,
    input  decode_pkg::word_t      rs2_data_i,
    output decode_pkg::reg_addr_t  rs1_o,
    output decode_pkg::reg_addr_t  rs2_o,
    output decode_pkg::reg_addr_t  rd_o,
    output decode_pkg::word_t      first_op_o,
    output decode_pkg::word_t      second_op_o,
    output decode_pkg::word_t      third_op_o,
    output decode_pkg::word_t      pc_o,
    output decode_pkg::word_t      instr_o,
    output decode_pkg::op_e        op_o,
    output logic                   hazard_o,
    output logic                   exc_illegal_o,
    output logic                   exc_misaligned_o
);
    import decode_pkg::*;

    word_t instr;
    word_t first_op;
    word_t second_op;
    word_t third_op;

    decode_if dec_bus ();

    instr_replay i_instr_replay (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .hazard_i (hazard_o),
        .instr_i  (instr_i),
        .instr_o  (instr)
    );

    op_decoder i_op_decoder (
        .instr_i (instr),
        .dec     (dec_bus.decoder)
    );

    operand_gen i_operand_gen (
        .dec         (dec_bus.consumer),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .first_op_o  (first_op),
        .second_op_o (second_op),
        .third_op_o  (third_op),
        .rs1_o       (rs1_o),
        .rs2_o       (rs2_o)
    );

    hazard_unit i_hazard_unit (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .jumped_i (jumped_i),
        .dec      (dec_bus.consumer),
        .hazard_o (hazard_o),
        .rd_o     (rd_o)
    );

    decode_out_reg #(
        .COMPRESSED (COMPRESSED)
    ) i_decode_out_reg (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (enable_i),
        .hazard_i         (hazard_o),
        .dec              (dec_bus.consumer),
        .pc_i             (pc_i),
        .first_op_i       (first_op),
        .second_op_i      (second_op),
        .third_op_i       (third_op),
        .first_op_o       (first_op_o),
        .second_op_o      (second_op_o),
        .third_op_o       (third_op_o),
        .pc_o             (pc_o),
        .instr_o          (instr_o),
        .op_o             (op_o),
        .exc_illegal_o    (exc_illegal_o),
        .exc_misaligned_o (exc_misaligned_o)
    );

endmodule

// ==== decode_assertions.sv ====
/*
 * Concurrent checks on the decode stage outputs
 * Bubble after a hazard, no hazard while stalled, delayed rd
 */
`timescale 1ns/100ps

module decode_assertions (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  enable_i,
    input logic                  hazard_i,
    input decode_pkg::op_e       op_i,
    input decode_pkg::word_t     issued_instr_i,
    input decode_pkg::reg_addr_t rd_i
);
    import decode_pkg::*;

    assert property (@(posedge clk) disable iff (!reset_n) hazard_i |=> (op_i == NOP))
        else $error("op_o is not a bubble after a hazard");

    assert property (@(posedge clk) disable iff (!reset_n) !enable_i |-> !hazard_i)
        else $error("hazard_o high while enable_i is low");

    // The rd field of the issued instruction mirrors the lock, bubbles included
    assert property (@(posedge clk) disable iff (!reset_n)
                     enable_i |=> (rd_i == $past(issued_instr_i[11:7])))
        else $error("rd_o does not follow the lock of the previous cycle");

endmodule

bind decode_stage decode_assertions i_decode_assertions (
    .clk            (clk),
    .reset_n        (reset_n),
    .enable_i       (enable_i),
    .hazard_i       (hazard_o),
    .op_i           (op_o),
    .issued_instr_i (instr_o),
    .rd_i           (rd_o)
);

// ==== tb_decode_model.svh ====
/*
 * Reference model of the decode stage
 * Decode tables, immediate rules, replay, lock and output register state
 */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

    localparam op_e ALU_OPS [8]    = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    localparam op_e MUL_OPS [8]    = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    localparam op_e BRANCH_OPS [8] = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    localparam op_e LOAD_OPS [8]   = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    localparam op_e STORE_OPS [8]  = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};

    // Replay and lock state
    logic      m_replay;
    word_t     m_last;
    reg_addr_t m_lock_rd;
    logic      m_lock_store;
    reg_addr_t m_rd;

    // Current cycle
    word_t     cur_instr;
    logic      cur_hazard;

    // Expected registered outputs
    word_t     exp_first;
    word_t     exp_second;
    word_t     exp_third;
    word_t     exp_pc;
    word_t     exp_instr;
    op_e       exp_op;
    logic      exp_illegal;
    logic      exp_misaligned;

    function automatic op_e lookup_op(input word_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        op_e        op;
        f3 = ins[14:12];
        f7 = ins[31:25];
        op = INVALID;
        case (ins[6:0])
            OPC_LUI:      op = LUI;
            OPC_AUIPC:    op = ADD;
            OPC_JAL:      op = JAL;
            OPC_JALR:     op = JALR;
            OPC_BRANCH:   op = BRANCH_OPS[f3];
            OPC_LOAD:     op = LOAD_OPS[f3];
            OPC_STORE:    op = STORE_OPS[f3];
            OPC_MISC_MEM: op = (f3 == 3'd0) ? NOP : INVALID;
            OPC_OP_IMM: begin
                op = ALU_OPS[f3];
                if (f3 == 3'd1 && f7 != 7'h00) op = INVALID;
                if (f3 == 3'd5 && f7 == 7'h20) op = SRA;
                else if (f3 == 3'd5 && f7 != 7'h00) op = INVALID;
            end
            OPC_OP: begin
                if (f7 == 7'h00) op = ALU_OPS[f3];
                else if (f7 == 7'h01) op = MUL_OPS[f3];
                else if (f7 == 7'h20 && f3 == 3'd0) op = SUB;
                else if (f7 == 7'h20 && f3 == 3'd5) op = SRA;
            end
            default:      op = INVALID;
        endcase
        return op;
    endfunction

    function automatic fmt_e lookup_format(input logic [6:0] opcode);
        if (opcode == OPC_JALR || opcode == OPC_LOAD || opcode == OPC_OP_IMM) return I_TYPE;
        if (opcode == OPC_STORE) return S_TYPE;
        if (opcode == OPC_BRANCH) return B_TYPE;
        if (opcode == OPC_LUI || opcode == OPC_AUIPC) return U_TYPE;
        if (opcode == OPC_JAL) return J_TYPE;
        return R_TYPE;
    endfunction

    // Sign extension by arithmetic shift of a left-aligned field
    function automatic word_t build_immediate(input word_t ins, input fmt_e fmt);
        case (fmt)
            I_TYPE:  return $signed(ins) >>> 20;
            S_TYPE:  return $signed({ins[31:25], ins[11:7], 20'h00000}) >>> 20;
            B_TYPE:  return $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'h0}) >>> 19;
            U_TYPE:  return {ins[31:12], 12'h000};
            J_TYPE:  return $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'h0}) >>> 11;
            default: return 32'h0000_0000;
        endcase
    endfunction

    // Fetch granule is a halfword with compressed fetch, a word otherwise
    function automatic logic pc_misaligned(input word_t pc);
        int unsigned align_bytes;
        align_bytes = COMPRESSED ? 2 : 4;
        return (pc % align_bytes) != 0;
    endfunction

    task automatic load_bubble();
        exp_first      = '0;
        exp_second     = '0;
        exp_third      = '0;
        exp_pc         = '0;
        exp_instr      = '0;
        exp_op         = NOP;
        exp_illegal    = 1'b0;
        exp_misaligned = 1'b0;
    endtask

    task automatic reset_model();
        m_replay     = 1'b1;
        m_last       = NOP_INSTR;
        m_lock_rd    = '0;
        m_lock_store = 1'b0;
        m_rd         = '0;
        load_bubble();
    endtask

    // Instruction and hazard seen before the coming edge
    task automatic predict_cycle();
        fmt_e      fmt;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      raw;
        cur_instr = m_replay ? m_last : instr_i;
        fmt = lookup_format(cur_instr[6:0]);
        rs1 = cur_instr[19:15];
        rs2 = cur_instr[24:20];
        raw = (fmt != U_TYPE && fmt != J_TYPE && rs1 != 5'd0 && rs1 == m_lock_rd) ||
              ((fmt == R_TYPE || fmt == S_TYPE || fmt == B_TYPE) &&
               rs2 != 5'd0 && rs2 == m_lock_rd);
        cur_hazard = enable_i && !jumped_i &&
                     (raw || (m_lock_store && cur_instr[6:0] == OPC_LOAD));
    endtask

    // State after the coming edge
    task automatic advance_model();
        fmt_e  fmt;
        word_t imm;
        word_t rs2_val;
        fmt = lookup_format(cur_instr[6:0]);
        imm = build_immediate(cur_instr, fmt);
        rs2_val = regfile[cur_instr[24:20]];
        if (enable_i) m_rd = m_lock_rd;
        if (cur_hazard) begin
            m_lock_rd    = '0;
            m_lock_store = 1'b0;
            load_bubble();
        end else if (enable_i) begin
            m_lock_rd      = cur_instr[11:7];
            m_lock_store   = (cur_instr[6:0] == OPC_STORE);
            exp_first      = (fmt == U_TYPE || fmt == J_TYPE) ? pc_i : regfile[cur_instr[19:15]];
            exp_second     = (fmt == R_TYPE || fmt == B_TYPE) ? rs2_val : imm;
            exp_third      = (fmt == S_TYPE) ? rs2_val : imm;
            exp_pc         = pc_i;
            exp_instr      = cur_instr;
            exp_op         = lookup_op(cur_instr);
            exp_illegal    = (exp_op == INVALID);
            exp_misaligned = pc_misaligned(pc_i);
        end
        m_last   = cur_instr;
        m_replay = cur_hazard || !enable_i;
    endtask

`endif

// ==== tb_decode_stage.sv ====
/*
 * Testbench for the decode stage
 * Clock, reset, random fetch stream, register file, compare tasks
 */
`timescale 1ns/100ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam bit COMPRESSED     = 1'b0;
    localparam int INSTR_COUNT    = 2000;
    localparam int ACCEPT_TIMEOUT = 64;

    // Mix of opcodes, loads and stores weighted up, one SYSTEM entry
    localparam logic [6:0] OPCODE_POOL [16] = '{
        OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM,
        OPC_OP, OPC_MISC_MEM, OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM, 7'b1110011, OPC_BRANCH
    };

    logic      clk = 1'b0;
    logic      reset_n;
    logic      enable_i;
    logic      jumped_i;
    word_t     instr_i;
    word_t     pc_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    reg_addr_t rs1_o;
    reg_addr_t rs2_o;
    reg_addr_t rd_o;
    word_t     first_op_o;
    word_t     second_op_o;
    word_t     third_op_o;
    word_t     pc_o;
    word_t     instr_o;
    op_e       op_o;
    logic      hazard_o;
    logic      exc_illegal_o;
    logic      exc_misaligned_o;

    word_t     regfile [32];
    integer    seed = 32'ha000_1635;
    int        hazard_count = 0;

    `include "tb_decode_model.svh"

    always #20 clk = ~clk;

    assign rs1_data_i = regfile[rs1_o];
    assign rs2_data_i = regfile[rs2_o];

    decode_stage #(
        .COMPRESSED (COMPRESSED)
    ) i_decode_stage (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (enable_i),
        .jumped_i         (jumped_i),
        .instr_i          (instr_i),
        .pc_i             (pc_i),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .rs1_o            (rs1_o),
        .rs2_o            (rs2_o),
        .rd_o             (rd_o),
        .first_op_o       (first_op_o),
        .second_op_o      (second_op_o),
        .third_op_o       (third_op_o),
        .pc_o             (pc_o),
        .instr_o          (instr_o),
        .op_o             (op_o),
        .hazard_o         (hazard_o),
        .exc_illegal_o    (exc_illegal_o),
        .exc_misaligned_o (exc_misaligned_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_word(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", what, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_op(input string what, input op_e expected, input op_e actual);
        if (actual !== expected) begin
            $display("error %s: expected %s, actual %s", what, expected.name(), actual.name());
            abort_run();
        end
    endtask

    task automatic compare_addr(input string what, input reg_addr_t expected,
                                input reg_addr_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %0d, actual %0d", what, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_outputs();
        compare_word("first_op_o", exp_first, first_op_o);
        compare_word("second_op_o", exp_second, second_op_o);
        compare_word("third_op_o", exp_third, third_op_o);
        compare_word("pc_o", exp_pc, pc_o);
        compare_word("instr_o", exp_instr, instr_o);
        compare_op("op_o", exp_op, op_o);
        compare_bit("exc_illegal_o", exp_illegal, exc_illegal_o);
        compare_bit("exc_misaligned_o", exp_misaligned, exc_misaligned_o);
        compare_addr("rd_o", m_rd, rd_o);
        compare_bit("hazard_o", cur_hazard, hazard_o);
        compare_addr("rs1_o", cur_instr[19:15], rs1_o);
        compare_addr("rs2_o", cur_instr[24:20], rs2_o);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic draw_controls();
        word_t ctl;
        ctl = $random(seed);
        enable_i <= (ctl[2:0] != 3'b000);
        jumped_i <= (ctl[6:3] == 4'h0);
    endtask

    task automatic draw_fetch();
        word_t      body;
        word_t      ctl;
        word_t      pc;
        logic [6:0] opc;
        body = $random(seed);
        ctl  = $random(seed);
        pc   = $random(seed);
        opc  = OPCODE_POOL[ctl[3:0]];
        // One fetch in eight keeps the raw random word
        if (ctl[15:13] != 3'b000) begin
            body[6:0] = opc;
            if (opc == OPC_OP || opc == OPC_OP_IMM) begin
                case (ctl[17:16])
                    2'd0:    body[31:25] = 7'h00;
                    2'd1:    body[31:25] = 7'h20;
                    2'd2:    body[31:25] = 7'h01;
                    default: ;
                endcase
            end
            if (opc == OPC_MISC_MEM && ctl[19]) body[14:12] = 3'b000;
            // Few registers in use so that dependencies are frequent
            if (ctl[5]) begin
                body[11:7]  = {3'b000, ctl[8:7]};
                body[19:15] = {3'b000, ctl[10:9]};
                body[24:20] = {3'b000, ctl[12:11]};
            end
        end
        if (ctl[20]) pc[1:0] = 2'b00;
        instr_i <= body;
        pc_i    <= pc;
    endtask

    // Check at the falling edge, then step to the next rising edge
    task automatic run_cycle(output logic accepted);
        @(negedge clk);
        predict_cycle();
        check_outputs();
        accepted = enable_i && !cur_hazard;
        if (cur_hazard) hazard_count = hazard_count + 1;
        advance_model();
        @(posedge clk);
    endtask

    task automatic wait_for_accept();
        logic accepted;
        int   waited;
        waited = 0;
        run_cycle(accepted);
        while (!accepted) begin
            waited = waited + 1;
            if (waited > ACCEPT_TIMEOUT) begin
                $display("instruction not accepted within %0d cycles", ACCEPT_TIMEOUT);
                abort_run();
            end else begin
                draw_controls();
                run_cycle(accepted);
            end
        end
    endtask

    initial begin
        reg_addr_t a;
        logic      drained;
        reset_n  = 1'b0;
        enable_i = 1'b0;
        jumped_i = 1'b0;
        instr_i  = NOP_INSTR;
        pc_i     = '0;
        a = '0;
        repeat (32) begin
            if (a == 5'd0) regfile[a] = '0;
            else regfile[a] = $random(seed);
            a = a + 1'b1;
        end
        reset_model();

        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        for (int n = 0; n < INSTR_COUNT; n++) begin
            draw_fetch();
            draw_controls();
            wait_for_accept();
        end

        // Let the last accepted instruction reach the outputs
        enable_i <= 1'b0;
        repeat (2) run_cycle(drained);

        if (hazard_count == 0) begin
            $display("no hazard was raised during the run");
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
+incdir+.
decode_pkg.sv
decode_if.sv
instr_replay.sv
op_decoder.sv
operand_gen.sv
hazard_unit.sv
decode_out_reg.sv
decode_stage.sv
decode_assertions.sv
tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module tb_decode_stage -o sim_decode
./obj_dir/sim_decode
